// ==== sources.f ====
rtl/uart_pkg.sv
rtl/matrix_pkg.sv
rtl/uart_rx.sv
rtl/uart_tx.sv
rtl/mode_ctrl.sv
rtl/matrix_parser.sv
rtl/matrix_store.sv
rtl/matrix_printer.sv
rtl/sys_top.sv
tests/sys_top_assert.sv
tests/tb_sys_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Verilator build and run of tb_sys_top

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -j 0 \
	--top-module tb_sys_top -f sources.f -o sim_tb > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
	echo "build failed, see $BUILD_LOG"
	exit 1
fi

./obj_dir/sim_tb > "$SIM_LOG" 2>&1
sim_status=$?
cat "$SIM_LOG"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -qx "Done: no errors" "$SIM_LOG"; then
	exit 0
fi
echo "pass message not found in $SIM_LOG"
exit 1

// ==== tests/tb_sys_top.sv ====
`timescale 1ns/1ps

module tb_sys_top;
	import uart_pkg::*;
	import matrix_pkg::*;

	localparam int  CLKS_PER_BIT    = 8;
	localparam int  DEBOUNCE_CYCLES = 4;
	localparam int  FLASH_CYCLES    = 50;
	localparam int  CLK_NS          = 100;
	localparam int  CHAR_CYCLES     = 12 * CLKS_PER_BIT; // one frame plus slack
	localparam int  TOTAL_CHARS     = 700;               // sent plus printed, upper bound
	localparam real TIMEOUT_NS      = 2.0 * TOTAL_CHARS * CHAR_CYCLES * CLK_NS;

	typedef byte_t text_t[$];

	logic       clk;
	logic       rst_n;
	logic [2:0] command;
	logic       btn_confirm;
	logic       uart_rxd;
	logic       uart_txd;
	logic [7:0] led;
	logic [7:0] ld2;

	int      seed      = 32'h4fac_4d89;
	int      err_count = 0;
	byte_t   exp_q[$];          // characters the printer still owes
	byte_t   got_char;          // last decoded tx character
	event    char_seen;
	matrix_t slot_data [SLOTS]; // reference store
	dim_t    slot_m    [SLOTS];
	dim_t    slot_n    [SLOTS];
	logic    slot_full [SLOTS];
	int      slot_ptr;          // round robin, slot 0 first

	sys_top #(
		.CLKS_PER_BIT(CLKS_PER_BIT),
		.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES),
		.FLASH_CYCLES(FLASH_CYCLES)
	) u_sys_top (
		.clk(clk), .rst_n(rst_n), .command(command), .btn_confirm(btn_confirm),
		.uart_rxd(uart_rxd), .uart_txd(uart_txd), .led(led), .ld2(ld2)
	);

	// ==============================
	// clock and watchdog
	// ==============================
	initial begin
		clk = 1'b0;
		forever #(CLK_NS / 2) clk = ~clk;
	end

	initial begin
		#(TIMEOUT_NS);
		stop_run("watchdog expired before the tests finished");
	end

	// ==============================
	// helpers
	// ==============================
	task automatic stop_run(input string msg);
		err_count++;
		$display("%s", msg);
		$display("Done: errors found");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic step_cycles(input int n);
		repeat (n) @(posedge clk);
		#10; // inputs change just after the edge
	endtask

	task automatic check_char(input byte_t got, input byte_t exp);
		if (got !== exp)
			stop_run($sformatf("MISMATCH at %0t: tx char 0x%02h, expected 0x%02h",
				$time, got, exp));
	endtask

	task automatic check_mode(input logic [7:0] got, input mode_t exp);
		logic [7:0] want;
		want = 8'd0;
		if (exp == MODE_INPUT)
			want[3] = 1'b1;
		if (exp == MODE_DISPLAY)
			want[1] = 1'b1;
		if (got !== want)
			stop_run($sformatf("MISMATCH at %0t: led 0x%02h, expected 0x%02h for mode %s",
				$time, got, want, exp.name()));
	endtask

	task automatic check_flag(input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp)
			stop_run($sformatf("MISMATCH at %0t: ld2 0x%02h, expected 0x%02h", $time, got, exp));
	endtask

	// printer format: digits split by spaces, CR LF after each row
	function automatic text_t expected_text(input dim_t m, input dim_t n, input matrix_t d);
		text_t t;
		for (int r = 0; r < int'(m); r++) begin
			for (int c = 0; c < int'(n); c++) begin
				t.push_back(CH_ZERO + d[r * MAX_DIM + c]);
				if (c != int'(n) - 1)
					t.push_back(CH_SPACE);
			end
			t.push_back(CH_CR);
			t.push_back(CH_LF);
		end
		return t;
	endfunction

	task automatic random_matrix(output dim_t m, output dim_t n, output matrix_t d);
		m = dim_t'(1 + $unsigned($random(seed)) % MAX_DIM);
		n = dim_t'(1 + $unsigned($random(seed)) % MAX_DIM);
		d = '0; // unused positions stay zero
		for (int r = 0; r < int'(m); r++)
			for (int c = 0; c < int'(n); c++)
				d[r * MAX_DIM + c] = elem_t'($unsigned($random(seed)) % (ELEM_MAX + 1));
	endtask

	task automatic send_byte(input byte_t b);
		logic [9:0] frame;
		frame = {1'b1, b, 1'b0}; // stop, data lsb first, start
		for (int i = 0; i < 10; i++) begin
			uart_rxd = frame[i];
			step_cycles(CLKS_PER_BIT);
		end
	endtask

	task automatic apply_reset();
		rst_n = 1'b0;
		step_cycles(5);
		rst_n = 1'b1;
		slot_ptr = 0;
		foreach (slot_full[i])
			slot_full[i] = 1'b0;
	endtask

	task automatic press_confirm(input logic [2:0] cmd, input mode_t exp);
		command     = cmd;
		btn_confirm = 1'b1;
		step_cycles(DEBOUNCE_CYCLES + 10); // well past the debounce window
		btn_confirm = 1'b0;
		step_cycles(DEBOUNCE_CYCLES + 10);
		check_mode(led, exp);
	endtask

	task automatic wait_drained(input string what);
		int limit;
		limit = (exp_q.size() + 4) * CHAR_CYCLES;
		while (exp_q.size() != 0 && limit > 0) begin
			@(posedge clk);
			limit--;
		end
		if (exp_q.size() != 0)
			stop_run($sformatf("timed out waiting for %s, %0d characters never arrived",
				what, exp_q.size()));
		step_cycles(2 * CHAR_CYCLES); // quiet window, stray chars show up here
	endtask

	// matrix text with separators mixed in, echo queued up front
	task automatic write_matrix(input dim_t m, input dim_t n, input matrix_t d);
		text_t t;
		t = expected_text(m, n, d);
		foreach (t[i])
			exp_q.push_back(t[i]);
		slot_data[slot_ptr] = d;
		slot_m[slot_ptr]    = m;
		slot_n[slot_ptr]    = n;
		slot_full[slot_ptr] = 1'b1;
		slot_ptr            = (slot_ptr + 1) % SLOTS;
		send_byte(CH_ZERO + 8'(m));
		send_byte(CH_SPACE);
		send_byte(CH_ZERO + 8'(n));
		send_byte(CH_CR);
		send_byte(CH_LF);
		for (int r = 0; r < int'(m); r++) begin
			for (int c = 0; c < int'(n); c++) begin
				send_byte(CH_ZERO + d[r * MAX_DIM + c]);
				if (c != int'(n) - 1)
					send_byte(CH_SPACE);
			end
			if (r != int'(m) - 1) begin
				send_byte(CH_CR);
				send_byte(CH_LF);
			end
		end
		step_cycles(6);
		check_flag(ld2, 8'h01); // stored flag while it is still lit
		send_byte(CH_CR);
		send_byte(CH_LF);
	endtask

	task automatic request_slot(input int s);
		text_t t;
		if (slot_full[s]) begin
			t = expected_text(slot_m[s], slot_n[s], slot_data[s]);
			foreach (t[i])
				exp_q.push_back(t[i]);
		end
		send_byte(CH_ZERO + 8'(s));
		step_cycles(6);
		check_flag(ld2, slot_full[s] ? 8'h00 : 8'h02); // reread never lights stored
		wait_drained($sformatf("reprint of slot %0d", s));
	endtask

	// ==============================
	// tx monitor and compare
	// ==============================
	initial begin
		byte_t ch;
		forever begin
			@(negedge uart_txd);
			repeat (CLKS_PER_BIT / 2) @(negedge clk); // near mid start bit
			if (uart_txd !== 1'b0)
				stop_run("start bit on uart_txd did not stay low");
			for (int i = 0; i < 8; i++) begin
				repeat (CLKS_PER_BIT) @(negedge clk);
				ch[i] = uart_txd;
			end
			repeat (CLKS_PER_BIT) @(negedge clk);
			if (uart_txd !== 1'b1)
				stop_run("stop bit on uart_txd was low");
			got_char = ch;
			-> char_seen;
		end
	end

	initial begin
		forever begin
			@(char_seen);
			if (exp_q.size() == 0)
				stop_run($sformatf("MISMATCH at %0t: unexpected tx char 0x%02h",
					$time, got_char));
			else
				check_char(got_char, exp_q.pop_front());
		end
	end

	// ==============================
	// test sequence
	// ==============================
	initial begin
		dim_t    m;
		dim_t    n;
		matrix_t d;
		rst_n       = 1'b0;
		command     = 3'd0;
		btn_confirm = 1'b0;
		uart_rxd    = 1'b1; // idle line
		apply_reset();

		// idle mode ignores everything
		if (uart_txd !== 1'b1)
			stop_run("uart_txd is not high after reset");
		check_mode(led, MODE_IDLE);
		check_flag(ld2, 8'h00);
		send_byte(CH_ZERO + 8'd3);
		send_byte("x");
		step_cycles(3 * CHAR_CYCLES);
		check_flag(ld2, 8'h00);

		// input mode, one echoed matrix
		press_confirm(3'd1, MODE_INPUT);
		random_matrix(m, n, d);
		write_matrix(m, n, d);
		wait_drained("echo of the first matrix");

		// partial matrix cut by a letter
		send_byte(CH_ZERO + 8'd2);
		send_byte(CH_ZERO + 8'd3);
		send_byte(CH_ZERO + 8'd4);
		send_byte("A");
		step_cycles(6);
		check_flag(ld2, 8'h02);
		step_cycles(FLASH_CYCLES + 5);
		check_flag(ld2, 8'h00);
		send_byte(CH_ZERO + 8'd6); // row count out of range
		step_cycles(6);
		check_flag(ld2, 8'h02);
		step_cycles(FLASH_CYCLES + 5);
		random_matrix(m, n, d);
		write_matrix(m, n, d);
		wait_drained("echo after parse errors");

		// three more writes, then reprint both slots
		for (int k = 0; k < 3; k++) begin
			random_matrix(m, n, d);
			write_matrix(m, n, d);
			wait_drained($sformatf("echo of write %0d", k));
		end
		press_confirm(3'd2, MODE_DISPLAY);
		request_slot(0);
		request_slot(1);

		// empty slot after a fresh reset
		apply_reset();
		check_mode(led, MODE_IDLE);
		press_confirm(3'd2, MODE_DISPLAY);
		request_slot(1);

		if (err_count == 0) begin
			$display("Done: no errors");
			$finish;
		end else begin
			$display("Done: errors found");
			$fatal(1, "checks failed");
		end
	end

endmodule

// ==== tests/sys_top_assert.sv ====
`timescale 1ns/1ps

module sys_top_assert (
	input logic              clk,
	input logic              rst_n,
	input logic              tx_en,
	input logic              tx_busy,
	input logic              wr_en,
	input logic              rd_en,
	input matrix_pkg::mode_t mode
);
	import matrix_pkg::*;

	// new character only into an idle transmitter
	assert property (@(posedge clk) disable iff (!rst_n) $rose(tx_en) |-> !tx_busy)
		else $error("tx_en rose while tx_busy was high");

	// parser never asks for a write and a read at once
	assert property (@(posedge clk) disable iff (!rst_n) !(wr_en && rd_en))
		else $error("wr_en and rd_en high together");

	assert property (@(posedge clk) disable iff (!rst_n)
		mode inside {MODE_IDLE, MODE_INPUT, MODE_DISPLAY})
		else $error("mode holds an undefined value");

endmodule

bind sys_top sys_top_assert u_sys_top_assert (
	.clk(clk), .rst_n(rst_n), .tx_en(tx_en), .tx_busy(tx_busy),
	.wr_en(wr_en), .rd_en(rd_en), .mode(mode)
);

// ==== rtl/sys_top.sv ====
`timescale 1ns/1ps

module sys_top #(
	parameter int CLKS_PER_BIT    = 434,       // 50 MHz at 115200 baud
	parameter int DEBOUNCE_CYCLES = 1_000_000, // about 20 ms
	parameter int FLASH_CYCLES    = 25_000_000 // half a second
) (
	input  logic       clk,
	input  logic       rst_n,
	input  logic [2:0] command,
	input  logic       btn_confirm,
	input  logic       uart_rxd,
	output logic       uart_txd,
	output logic [7:0] led,
	output logic [7:0] ld2
);
	import uart_pkg::*;
	import matrix_pkg::*;

	// ==============================
	// interconnect
	// ==============================
	byte_t   rx_data;
	logic    rx_done;
	logic    tx_en;
	byte_t   tx_data;
	logic    tx_busy;
	mode_t   mode;
	logic    wr_en;       // parser to store
	dim_t    wr_m;
	dim_t    wr_n;
	matrix_t wr_data;
	logic    rd_en;
	slot_t   rd_index;
	logic    parse_error;
	logic    out_valid;   // store to printer
	dim_t    out_m;
	dim_t    out_n;
	matrix_t out_data;
	logic    rd_error;
	logic    written;

	uart_rx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart_rx (
		.clk(clk), .rst_n(rst_n), .uart_rxd(uart_rxd),
		.rx_data(rx_data), .rx_done(rx_done)
	);

	mode_ctrl #(.DEBOUNCE_CYCLES(DEBOUNCE_CYCLES), .FLASH_CYCLES(FLASH_CYCLES)) u_mode_ctrl (
		.clk(clk), .rst_n(rst_n), .command(command), .btn_confirm(btn_confirm),
		.store_flag({out_valid, written}), .error_flag({parse_error, rd_error}),
		.mode(mode), .led(led), .ld2(ld2)
	);

	matrix_parser u_parser (
		.clk(clk), .rst_n(rst_n), .mode(mode), .rx_data(rx_data), .rx_done(rx_done),
		.wr_en(wr_en), .wr_m(wr_m), .wr_n(wr_n), .wr_data(wr_data),
		.rd_en(rd_en), .rd_index(rd_index), .parse_error(parse_error)
	);

	matrix_store u_store (
		.clk(clk), .rst_n(rst_n), .wr_en(wr_en), .wr_m(wr_m), .wr_n(wr_n), .wr_data(wr_data),
		.rd_en(rd_en), .rd_index(rd_index), .out_valid(out_valid), .out_m(out_m),
		.out_n(out_n), .out_data(out_data), .rd_error(rd_error), .written(written)
	);

	// one printer serves both echo and reprint
	matrix_printer u_printer (
		.clk(clk), .rst_n(rst_n), .start(out_valid), .m(out_m), .n(out_n), .data(out_data),
		.tx_busy(tx_busy), .tx_en(tx_en), .tx_data(tx_data),
		.busy(), .done()
	);

	uart_tx #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_uart_tx (
		.clk(clk), .rst_n(rst_n), .tx_en(tx_en), .tx_data(tx_data),
		.uart_txd(uart_txd), .tx_busy(tx_busy)
	);

endmodule

// ==== rtl/matrix_printer.sv ====
`timescale 1ns/1ps

module matrix_printer (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                start,
	input  matrix_pkg::dim_t    m,
	input  matrix_pkg::dim_t    n,
	input  matrix_pkg::matrix_t data,
	input  logic                tx_busy,
	output logic                tx_en,
	output uart_pkg::byte_t     tx_data,
	output logic                busy,
	output logic                done
);
	import uart_pkg::*;
	import matrix_pkg::*;

	typedef enum logic [1:0] {
		PR_IDLE,
		PR_SEND,    // wait for a free transmitter, then fire
		PR_WAIT_HI, // character accepted
		PR_WAIT_LO  // character on the line
	} pr_state_t;

	typedef enum logic [1:0] {
		PH_DIGIT,
		PH_SPACE,
		PH_CR,
		PH_LF
	} phase_t;

	pr_state_t  state;
	phase_t     phase;
	dim_t       m_q;
	dim_t       n_q;
	dim_t       row;
	dim_t       col;
	matrix_t    mat_q;
	logic [4:0] idx;
	byte_t      ch;    // character for the current phase

	assign idx  = 5'(row) * 5'(MAX_DIM) + 5'(col);
	assign busy = (state != PR_IDLE);

	always_comb begin
		case (phase)
			PH_DIGIT: ch = CH_ZERO + mat_q[idx];
			PH_SPACE: ch = CH_SPACE;
			PH_CR:    ch = CH_CR;
			default:  ch = CH_LF;
		endcase
	end

	// ==============================
	// sequencing
	// ==============================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= PR_IDLE;
			phase <= PH_DIGIT;
			row   <= '0;
			col   <= '0;
			tx_en <= 1'b0;
			done  <= 1'b0;
		end else begin
			tx_en <= 1'b0;
			done  <= 1'b0;
			case (state)
				PR_IDLE: begin
					if (start) begin // start while busy is dropped
						state <= PR_SEND;
						phase <= PH_DIGIT;
						row   <= '0;
						col   <= '0;
					end
				end
				PR_SEND: begin
					if (!tx_busy) begin
						tx_en <= 1'b1;
						state <= PR_WAIT_HI;
					end
				end
				PR_WAIT_HI: begin
					if (tx_busy)
						state <= PR_WAIT_LO;
				end
				PR_WAIT_LO: begin
					if (!tx_busy) begin
						state <= PR_SEND;
						case (phase)
							PH_DIGIT: phase <= (col == n_q - 1'b1) ? PH_CR : PH_SPACE;
							PH_SPACE: begin
								phase <= PH_DIGIT;
								col   <= col + 1'b1;
							end
							PH_CR:    phase <= PH_LF;
							default: begin // LF closes the row
								phase <= PH_DIGIT;
								col   <= '0;
								if (row == m_q - 1'b1) begin
									state <= PR_IDLE;
									done  <= 1'b1;
								end else
									row <= row + 1'b1;
							end
						endcase
					end
				end
				default: state <= PR_IDLE;
			endcase
		end
	end

	// matrix copy and outgoing character
	always_ff @(posedge clk) begin
		if (state == PR_IDLE && start) begin
			m_q   <= m;
			n_q   <= n;
			mat_q <= data;
		end
		if (state == PR_SEND && !tx_busy)
			tx_data <= ch;
	end

endmodule

// ==== rtl/matrix_store.sv ====
`timescale 1ns/1ps

module matrix_store (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                wr_en,
	input  matrix_pkg::dim_t    wr_m,
	input  matrix_pkg::dim_t    wr_n,
	input  matrix_pkg::matrix_t wr_data,
	input  logic                rd_en,
	input  matrix_pkg::slot_t   rd_index,
	output logic                out_valid,
	output matrix_pkg::dim_t    out_m,
	output matrix_pkg::dim_t    out_n,
	output matrix_pkg::matrix_t out_data,
	output logic                rd_error,
	output logic                written
);
	import matrix_pkg::*;

	matrix_t          mem_data [SLOTS];
	dim_t             mem_m    [SLOTS];
	dim_t             mem_n    [SLOTS];
	logic [SLOTS-1:0] filled;  // slot has been written since reset
	slot_t            wr_ptr;  // round robin, slot 0 first

	// ==============================
	// slot bookkeeping
	// ==============================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			filled    <= '0;
			wr_ptr    <= '0;
			out_valid <= 1'b0;
			written   <= 1'b0;
			rd_error  <= 1'b0;
		end else begin
			out_valid <= 1'b0;
			written   <= 1'b0;
			rd_error  <= 1'b0;
			if (wr_en) begin
				filled[wr_ptr] <= 1'b1;
				wr_ptr    <= (wr_ptr == slot_t'(SLOTS - 1)) ? '0 : wr_ptr + 1'b1;
				out_valid <= 1'b1; // echo
				written   <= 1'b1;
			end else if (rd_en) begin
				out_valid <= filled[rd_index];
				rd_error  <= !filled[rd_index]; // empty slot
			end
		end
	end

	// ==============================
	// matrix memory and output
	// ==============================
	always_ff @(posedge clk) begin
		if (wr_en) begin
			mem_data[wr_ptr] <= wr_data;
			mem_m[wr_ptr]    <= wr_m;
			mem_n[wr_ptr]    <= wr_n;
			out_data         <= wr_data; // new matrix goes straight out
			out_m            <= wr_m;
			out_n            <= wr_n;
		end else if (rd_en) begin
			out_data <= mem_data[rd_index];
			out_m    <= mem_m[rd_index];
			out_n    <= mem_n[rd_index];
		end
	end

endmodule

// ==== rtl/matrix_parser.sv ====
`timescale 1ns/1ps

module matrix_parser (
	input  logic                clk,
	input  logic                rst_n,
	input  matrix_pkg::mode_t   mode,
	input  uart_pkg::byte_t     rx_data,
	input  logic                rx_done,
	output logic                wr_en,
	output matrix_pkg::dim_t    wr_m,
	output matrix_pkg::dim_t    wr_n,
	output matrix_pkg::matrix_t wr_data,
	output logic                rd_en,
	output matrix_pkg::slot_t   rd_index,
	output logic                parse_error
);
	import uart_pkg::*;
	import matrix_pkg::*;

	typedef enum logic [1:0] {
		ST_ROWS,  // waiting for row count
		ST_COLS,  // waiting for col count
		ST_ELEMS
	} ps_state_t;

	ps_state_t  state;
	mode_t      mode_q;   // last mode, to spot a change
	dim_t       row;
	dim_t       col;
	logic [4:0] idx;      // flat element position
	byte_t      dval;     // byte minus '0'
	logic       is_digit;
	logic       is_sep;
	logic       is_dim;

	assign dval     = rx_data - CH_ZERO;
	assign is_digit = (rx_data >= CH_ZERO) && (dval <= byte_t'(ELEM_MAX));
	assign is_sep   = (rx_data == CH_SPACE) || (rx_data == CH_CR) || (rx_data == CH_LF);
	assign is_dim   = is_digit && (dval != 8'd0) && (dval <= byte_t'(MAX_DIM));
	assign idx      = 5'(row) * 5'(MAX_DIM) + 5'(col);

	// ==============================
	// control
	// ==============================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state       <= ST_ROWS;
			mode_q      <= MODE_IDLE;
			row         <= '0;
			col         <= '0;
			wr_en       <= 1'b0;
			rd_en       <= 1'b0;
			parse_error <= 1'b0;
		end else begin
			mode_q      <= mode;
			wr_en       <= 1'b0;
			rd_en       <= 1'b0;
			parse_error <= 1'b0;
			if (mode != mode_q) begin
				state <= ST_ROWS; // partial matrix is dropped
			end else if (rx_done && mode == MODE_DISPLAY) begin
				if (is_digit && dval < byte_t'(SLOTS))
					rd_en <= 1'b1;
				else
					parse_error <= 1'b1;
			end else if (rx_done && mode == MODE_INPUT && !is_sep) begin
				case (state)
					ST_ROWS: begin
						if (is_dim)
							state <= ST_COLS;
						else
							parse_error <= 1'b1;
					end
					ST_COLS: begin
						row   <= '0;
						col   <= '0;
						state <= is_dim ? ST_ELEMS : ST_ROWS;
						parse_error <= !is_dim;
					end
					ST_ELEMS: begin
						if (!is_digit) begin
							parse_error <= 1'b1;
							state       <= ST_ROWS;
						end else if (col != wr_n - 1'b1) begin
							col <= col + 1'b1;
						end else begin
							col <= '0; // end of row
							if (row == wr_m - 1'b1) begin
								wr_en <= 1'b1; // last element in
								state <= ST_ROWS;
							end else
								row <= row + 1'b1;
						end
					end
					default: state <= ST_ROWS;
				endcase
			end
		end
	end

	// ==============================
	// captured values
	// ==============================
	always_ff @(posedge clk) begin
		if (rx_done && mode == mode_q) begin
			if (mode == MODE_DISPLAY)
				rd_index <= slot_t'(dval);
			else if (mode == MODE_INPUT && state == ST_ROWS && is_dim) begin
				wr_m    <= dim_t'(dval);
				wr_data <= '0; // unused positions read as zero
			end else if (mode == MODE_INPUT && state == ST_COLS && is_dim)
				wr_n <= dim_t'(dval);
			else if (mode == MODE_INPUT && state == ST_ELEMS && is_digit)
				wr_data[idx] <= elem_t'(dval);
		end
	end

endmodule

// ==== rtl/mode_ctrl.sv ====
`timescale 1ns/1ps

module mode_ctrl #(
	parameter int DEBOUNCE_CYCLES = 1_000_000,
	parameter int FLASH_CYCLES    = 25_000_000
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic [2:0]        command,
	input  logic              btn_confirm,
	input  logic [1:0]        store_flag, // {out_valid, written}
	input  logic [1:0]        error_flag, // {parse_error, rd_error}
	output matrix_pkg::mode_t mode,
	output logic [7:0]        led,
	output logic [7:0]        ld2
);
	import matrix_pkg::*;

	localparam int DW = $clog2(DEBOUNCE_CYCLES + 1);
	localparam int FW = $clog2(FLASH_CYCLES + 1);

	logic [1:0]    btn_sync;
	logic          btn_db;   // debounced level
	logic [DW-1:0] db_cnt;
	logic          press;    // one cycle per confirmed press
	logic [1:0]    flash_ev; // bit 0 stored, bit 1 error

	// ==============================
	// confirm button
	// ==============================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			btn_sync <= 2'b00;
			btn_db   <= 1'b0;
			db_cnt   <= '0;
			press    <= 1'b0;
		end else begin
			btn_sync <= {btn_sync[0], btn_confirm};
			press    <= 1'b0;
			if (btn_sync[1] == btn_db) begin
				db_cnt <= '0; // bounce restarts the wait
			end else if (db_cnt == DW'(DEBOUNCE_CYCLES - 1)) begin
				db_cnt <= '0;
				btn_db <= btn_sync[1];
				press  <= btn_sync[1]; // rising edge only
			end else begin
				db_cnt <= db_cnt + 1'b1;
			end
		end
	end

	// ==============================
	// mode latch and mode leds
	// ==============================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			mode <= MODE_IDLE;
			led  <= 8'd0;
		end else begin
			if (press) begin
				case (command)
					3'd1:    mode <= MODE_INPUT;
					3'd2:    mode <= MODE_DISPLAY;
					default: mode <= MODE_IDLE;
				endcase
			end
			// led[3] input, led[1] display
			led <= {4'd0, mode == MODE_INPUT, 1'b0, mode == MODE_DISPLAY, 1'b0};
		end
	end

	// ==============================
	// event stretchers
	// ==============================
	assign flash_ev[0] = store_flag[1] & store_flag[0]; // echo of a write, not a reread
	assign flash_ev[1] = error_flag[1] | error_flag[0];

	for (genvar i = 0; i < 2; i++) begin : g_flash
		logic          on;
		logic [FW-1:0] cnt;

		always_ff @(posedge clk or negedge rst_n) begin
			if (!rst_n) begin
				on  <= 1'b0;
				cnt <= '0;
			end else if (flash_ev[i]) begin
				on  <= 1'b1;
				cnt <= '0; // new event restarts the count
			end else if (on) begin
				if (cnt == FW'(FLASH_CYCLES - 1))
					on <= 1'b0;
				else
					cnt <= cnt + 1'b1;
			end
		end
	end

	assign ld2 = {6'd0, g_flash[1].on, g_flash[0].on};

endmodule

// ==== rtl/uart_tx.sv ====
`timescale 1ns/1ps

module uart_tx #(
	parameter int CLKS_PER_BIT = 434
) (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            tx_en,
	input  uart_pkg::byte_t tx_data,
	output logic            uart_txd,
	output logic            tx_busy
);

	localparam int CW = $clog2(CLKS_PER_BIT + 1);
	localparam logic [CW-1:0] FULL = CW'(CLKS_PER_BIT - 1);

	logic [8:0]    frame;   // data bits then stop
	logic [CW-1:0] cnt;
	logic [3:0]    bit_idx; // 0 start, 1..8 data, 9 stop

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			uart_txd <= 1'b1;
			tx_busy  <= 1'b0;
			frame    <= '1;
			cnt      <= '0;
			bit_idx  <= '0;
		end else if (!tx_busy) begin
			if (tx_en) begin // tx_en while busy never gets here
				uart_txd <= 1'b0; // start bit
				tx_busy  <= 1'b1;
				frame    <= {1'b1, tx_data};
				cnt      <= '0;
				bit_idx  <= '0;
			end
		end else if (cnt != FULL) begin
			cnt <= cnt + 1'b1;
		end else begin
			cnt <= '0;
			if (bit_idx == 4'd9) begin
				tx_busy <= 1'b0; // end of stop bit, line stays high
			end else begin
				uart_txd <= frame[0];
				frame    <= {1'b1, frame[8:1]};
				bit_idx  <= bit_idx + 1'b1;
			end
		end
	end

endmodule

// ==== rtl/uart_rx.sv ====
`timescale 1ns/1ps

module uart_rx #(
	parameter int CLKS_PER_BIT = 434
) (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            uart_rxd,
	output uart_pkg::byte_t rx_data,
	output logic            rx_done
);
	import uart_pkg::*;

	localparam int CW = $clog2(CLKS_PER_BIT + 1);
	localparam logic [CW-1:0] FULL = CW'(CLKS_PER_BIT - 1);
	localparam logic [CW-1:0] HALF = CW'(CLKS_PER_BIT / 2 - 1); // middle of start bit

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_t;

	logic [1:0]    rxd_sync; // two-flop synchronizer
	logic          rxd;
	rx_state_t     state;
	logic [CW-1:0] cnt;      // clocks within the bit
	logic [2:0]    bit_idx;
	byte_t         shreg;

	assign rxd = rxd_sync[1];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			rxd_sync <= 2'b11; // idle line is high
			state    <= RX_IDLE;
			cnt      <= '0;
			bit_idx  <= '0;
			rx_done  <= 1'b0;
		end else begin
			rxd_sync <= {rxd_sync[0], uart_rxd};
			rx_done  <= 1'b0;
			case (state)
				RX_IDLE: begin
					cnt     <= '0;
					bit_idx <= '0;
					if (!rxd)
						state <= RX_START; // falling edge
				end
				RX_START: begin
					if (cnt == HALF) begin
						cnt   <= '0;
						state <= rxd ? RX_IDLE : RX_DATA; // high again means a glitch
					end else
						cnt <= cnt + 1'b1;
				end
				RX_DATA: begin
					if (cnt == FULL) begin
						cnt     <= '0;
						bit_idx <= bit_idx + 1'b1;
						if (bit_idx == 3'd7)
							state <= RX_STOP;
					end else
						cnt <= cnt + 1'b1;
				end
				RX_STOP: begin
					if (cnt == FULL) begin
						cnt     <= '0;
						rx_done <= rxd; // low stop bit drops the frame
						state   <= RX_IDLE;
					end else
						cnt <= cnt + 1'b1;
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

	// data path
	always_ff @(posedge clk) begin
		if (state == RX_DATA && cnt == FULL)
			shreg <= {rxd, shreg[7:1]}; // lsb arrives first
		if (state == RX_STOP && cnt == FULL && rxd)
			rx_data <= shreg;
	end

endmodule

// ==== rtl/matrix_pkg.sv ====
package matrix_pkg;

	// ==============================
	// dimensions
	// ==============================
	localparam int MAX_DIM = 5;  // rows and cols alike
	typedef logic [2:0] dim_t;   // only 1..MAX_DIM is legal

	// ==============================
	// elements
	// ==============================
	localparam int ELEM_MAX = 9; // single decimal digit, min is 0
	typedef logic [7:0] elem_t;

	// row-major, element (r,c) at r*MAX_DIM+c, 200 bits in all
	typedef elem_t [MAX_DIM*MAX_DIM-1:0] matrix_t;

	// ==============================
	// store slots and console mode
	// ==============================
	localparam int SLOTS = 2;
	typedef logic slot_t;

	typedef enum logic [1:0] {
		MODE_IDLE    = 2'd0,
		MODE_INPUT   = 2'd1, // text in, echo out
		MODE_DISPLAY = 2'd2  // slot digit in, reprint out
	} mode_t;

endpackage

// ==== rtl/uart_pkg.sv ====
package uart_pkg;

	// ==============================
	// serial character
	// ==============================
	typedef logic [7:0] byte_t; // one 8N1 character

	// ==============================
	// ascii codes used on the line
	// ==============================
	localparam byte_t CH_ZERO  = 8'h30; // ascii '0' plus the digit value
	localparam byte_t CH_SPACE = 8'h20; // element separator
	localparam byte_t CH_CR    = 8'h0d;
	localparam byte_t CH_LF    = 8'h0a;

endpackage
